//--- Bender.yml
package:
  name: wbuf

sources:
  - wbuf_pkg.sv
  - wbuf_scm.sv
  - wbuf_gidx_cache.sv
  - wbuf_ctrl.sv
  - wbuf_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_wbuf_top.sv

//--- src.f
wbuf_pkg.sv
wbuf_scm.sv
wbuf_gidx_cache.sv
wbuf_ctrl.sv
wbuf_top.sv
tb_clk_gen.sv
tb_wbuf_top.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned Period    = 8,
  parameter int unsigned RstCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, clear of the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_wbuf_top.sv
`timescale 1ns/1ps

module tb_wbuf_top;

  import wbuf_pkg::*;

  localparam int unsigned DW     = 64;
  localparam int unsigned Height = 4;
  localparam int unsigned NRegs  = 1;
  localparam int unsigned GidxW  = 3;
  localparam int unsigned D      = DW / ELEM_W;
  localparam int unsigned E      = NRegs + 1;
  localparam int unsigned C      = D / E;

  logic               clk;
  logic               rst_n;
  logic               clear;
  wbuf_ctrl_t         ctrl;
  logic [DW-1:0]      w_buffer_in;
  logic [GidxW-1:0]   gidx;
  wbuf_flags_t        flags;
  elem_t [Height-1:0] w_buffer_out;

  // Reference model of storage, tags and counters
  elem_t            m_mem [Height][D];
  logic [GidxW-1:0] m_rtag [Height];
  logic [GidxW-1:0] m_wtag [Height];
  bit               m_rvld [Height];
  bit               m_wvld [Height];
  int               m_usage [Height];
  int               m_row;
  int               m_el;
  int               m_col;
  dim_t             cur_width;
  dim_t             cur_height;

  int errors;
  int checks;
  int tests_run;
  int tests_failed;

  tb_clk_gen #(.Period(8), .RstCycles(5)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  wbuf_top #(
    .DW     (DW),
    .Height (Height),
    .NRegs  (NRegs),
    .GidxW  (GidxW)
  ) uut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .clear_i    (clear),
    .ctrl_i     (ctrl),
    .w_buffer_i (w_buffer_in),
    .gidx_i     (gidx),
    .flags_o    (flags),
    .w_buffer_o (w_buffer_out)
  );

  task automatic check_elem(input string name, input elem_t got, input elem_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input wbuf_flags_t got, input wbuf_flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic reset_model();
    for (int h = 0; h < Height; h++) begin
      for (int d = 0; d < D; d++) begin
        m_mem[h][d] = '0;
      end
      m_rtag[h]  = '0;
      m_wtag[h]  = '0;
      m_rvld[h]  = 1'b0;
      m_wvld[h]  = 1'b0;
      m_usage[h] = 0;
    end
    m_row = 0;
    m_el  = 0;
    m_col = 0;
  endtask

  function automatic bit group_present(input logic [GidxW-1:0] g);
    for (int h = 0; h < Height; h++) begin
      if (m_wvld[h] && m_wtag[h] == g) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Lowest storage row whose passes are used up
  function automatic int lowest_exhausted_row();
    for (int h = 0; h < Height; h++) begin
      if (m_usage[h] == 0) begin
        return h;
      end
    end
    return 0;
  endfunction

  // First stored row holding the group this lane consumes
  function automatic elem_t expected_lane(input int h, input bit dq);
    int r;
    bit found;
    r     = h;
    found = 1'b0;
    if (dq && m_rvld[h]) begin
      for (int s = 0; s < Height; s++) begin
        if (!found && m_wvld[s] && m_wtag[s] == m_rtag[h]) begin
          r     = s;
          found = 1'b1;
        end
      end
    end
    return m_mem[r][m_col * E + m_el];
  endfunction

  // State change at one rising edge
  task automatic advance_model(input bit load, input bit shift, input bit dq, input bit clr,
                               input logic [DW-1:0] data, input logic [GidxW-1:0] g);
    bit accept;
    int ev;
    int wr;
    accept = load && (!dq || !group_present(g));
    ev     = lowest_exhausted_row();
    wr     = dq ? ev : m_row;
    if (clr) begin
      reset_model();
      return;
    end
    if (accept) begin
      for (int d = 0; d < D; d++) begin
        m_mem[wr][d] = (d < int'(cur_width) && m_row < int'(cur_height)) ?
                       data[d*ELEM_W +: ELEM_W] : '0;
      end
    end
    if (load && dq) begin
      m_rtag[m_row] = g;
      m_rvld[m_row] = 1'b1;
    end
    for (int h = 0; h < Height; h++) begin
      if (accept && dq && h == ev) begin
        m_wtag[h]  = g;
        m_wvld[h]  = 1'b1;
        m_usage[h] = C - 1;
      end else if (shift && m_el == NRegs && m_usage[h] > 0) begin
        m_usage[h]--;
      end
    end
    if (load) begin
      m_row = (m_row == Height - 1) ? 0 : m_row + 1;
    end
    if (shift) begin
      if (m_el == NRegs) begin
        m_el  = 0;
        m_col = (m_col == C - 1) ? 0 : m_col + 1;
      end else begin
        m_el++;
      end
    end
  endtask

  // Entered 1 ns after a rising edge and left 1 ns after the next one
  task automatic run_cycle(input bit load, input bit shift, input bit dq, input bit clr,
                           input logic [DW-1:0] data, input logic [GidxW-1:0] g);
    wbuf_flags_t exp_flags;
    ctrl.load         = load;
    ctrl.shift        = shift;
    ctrl.dequant      = dq;
    ctrl.width        = cur_width;
    ctrl.height       = cur_height;
    clear             = clr;
    w_buffer_in       = data;
    gidx              = g;
    exp_flags.w_ready = load && (!dq || !group_present(g));
    #5;
    for (int h = 0; h < Height; h++) begin
      check_elem($sformatf("w_buffer_o[%0d]", h), w_buffer_out[h], expected_lane(h, dq));
    end
    check_flags("flags_o", flags, exp_flags);
    @(posedge clk);
    advance_model(load, shift, dq, clr, data, g);
    #1;
  endtask

  function automatic logic [DW-1:0] rand_row();
    return {$urandom, $urandom};
  endfunction

  task automatic flag_timeout(input string what);
    errors++;
    $display("Timeout: %s did not happen within the cycle limit", what);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, errors - err_before);
    end else begin
      $display("PASS %s", name);
    end
  endtask

  task automatic load_and_read_plain();
    int err_before;
    err_before = errors;
    cur_width  = D;
    cur_height = Height;
    for (int r = 0; r < Height; r++) begin
      run_cycle(1'b1, 1'b0, 1'b0, 1'b0, rand_row(), '0);
    end
    for (int s = 0; s < D; s++) begin
      run_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
    end
    report_test("plain_load", err_before);
  endtask

  task automatic pad_with_zeros();
    int err_before;
    err_before = errors;
    cur_width  = 3;
    cur_height = 2;
    for (int r = 0; r < Height; r++) begin
      run_cycle(1'b1, 1'b0, 1'b0, 1'b0, rand_row(), '0);
    end
    for (int s = 0; s < D; s++) begin
      run_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
    end
    report_test("zero_pad", err_before);
  endtask

  task automatic clear_storage();
    int err_before;
    err_before = errors;
    cur_width  = D;
    cur_height = Height;
    run_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0, '0);  // Move off element 0
    run_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, '0);
    run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);  // All lanes zero here
    run_cycle(1'b1, 1'b0, 1'b0, 1'b0, rand_row(), '0);
    run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    report_test("clear", err_before);
  endtask

  task automatic hit_known_group();
    int err_before;
    err_before = errors;
    run_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, '0);
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, rand_row(), 3'd1);
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, rand_row(), 3'd2);
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, rand_row(), 3'd1);  // Hit so the row is dropped
    run_cycle(1'b0, 1'b0, 1'b1, 1'b0, '0, '0);
    run_cycle(1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
    run_cycle(1'b0, 1'b0, 1'b1, 1'b0, '0, '0);
    report_test("group_hit", err_before);
  endtask

  task automatic evict_exhausted_row();
    int err_before;
    int n;
    err_before = errors;
    run_cycle(1'b0, 1'b0, 1'b0, 1'b1, '0, '0);
    for (int g = 0; g < Height; g++) begin
      run_cycle(1'b1, 1'b0, 1'b1, 1'b0, rand_row(), GidxW'(g));
    end
    // Shift until some storage row has no passes left
    n = 0;
    while (m_usage[lowest_exhausted_row()] != 0 && n < 4 * D) begin
      run_cycle(1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
      n++;
    end
    if (n >= 4 * D) begin
      flag_timeout("usage counter exhaustion");
    end
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, rand_row(), 3'd5);
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, rand_row(), 3'd6);
    for (int s = 0; s < D; s++) begin
      run_cycle(1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
    end
    report_test("eviction", err_before);
  endtask

  task automatic print_summary();
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin
    int n;
    void'($urandom(32'h66cb96dd));
    clear        = 1'b0;
    ctrl         = '0;
    w_buffer_in  = '0;
    gidx         = '0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_width    = D;
    cur_height   = Height;
    reset_model();
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (n >= 20) begin
      flag_timeout("reset release");
    end
    @(posedge clk);
    #1;
    load_and_read_plain();
    pad_with_zeros();
    clear_storage();
    hit_known_group();
    evict_exhausted_row();
    print_summary();
  end

endmodule

//--- wbuf_ctrl.sv
`timescale 1ns/1ps

module wbuf_ctrl #(
  parameter  int unsigned DW     = wbuf_pkg::DEF_DW,
  parameter  int unsigned Height = wbuf_pkg::DEF_HEIGHT,
  parameter  int unsigned NRegs  = wbuf_pkg::DEF_NREGS,
  localparam int unsigned D      = DW / wbuf_pkg::ELEM_W,
  localparam int unsigned E      = NRegs + 1,
  localparam int unsigned C      = D / E,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1,
  localparam int unsigned ElW    = (E > 1) ? $clog2(E) : 1,
  localparam int unsigned ColW   = (C > 1) ? $clog2(C) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  wbuf_pkg::wbuf_ctrl_t          ctrl_i,
  input  logic            [DW-1:0]      w_buffer_i,
  // From the group index cache
  input  logic                          gidx_present_i,
  input  logic            [RowW-1:0]    evict_ptr_i,
  output wbuf_pkg::wbuf_flags_t         flags_o,
  // To the storage array
  output logic                          write_en_o,
  output logic            [RowW-1:0]    write_addr_o,
  output wbuf_pkg::elem_t [D-1:0]       wdata_o,
  output logic            [ElW-1:0]     el_addr_o,
  output logic            [ColW-1:0]    col_addr_o,
  // To the group index cache
  output logic            [RowW-1:0]    w_row_o,
  output logic                          el_wrap_o
);

  import wbuf_pkg::*;

  logic [RowW-1:0] w_row_q;
  logic [ElW-1:0]  el_q, el_d;
  logic [ColW-1:0] col_q, col_d;
  logic            row_in_range;
  logic            el_wrap;

  // Rows past the programmed height are written as zeros
  assign row_in_range = int'(w_row_q) < int'(ctrl_i.height);

  for (genvar d = 0; d < D; d++) begin : gen_pad
    assign wdata_o[d] = (d < int'(ctrl_i.width) && row_in_range) ?
                        w_buffer_i[d*ELEM_W +: ELEM_W] : '0;
  end

  // A known group in dequant mode is not stored twice
  assign write_en_o      = ctrl_i.load && (!ctrl_i.dequant || !gidx_present_i);
  assign write_addr_o    = ctrl_i.dequant ? evict_ptr_i : w_row_q;
  assign flags_o.w_ready = write_en_o;

  // Row counter steps on every load, accepted or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_row_q <= '0;
    end else if (clear_i) begin
      w_row_q <= '0;
    end else if (ctrl_i.load) begin
      if (w_row_q == RowW'(Height - 1)) begin
        w_row_q <= '0;
      end else begin
        w_row_q <= w_row_q + 1'b1;
      end
    end
  end

  // Element within a pass, then column once a pass is done
  assign el_wrap = (el_q == ElW'(NRegs));
  assign el_d    = el_wrap ? '0 : el_q + 1'b1;

  always_comb begin
    col_d = col_q;
    if (el_wrap) begin
      col_d = (col_q == ColW'(C - 1)) ? '0 : col_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (clear_i) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (ctrl_i.shift) begin
      el_q  <= el_d;
      col_q <= col_d;
    end
  end

  assign el_addr_o  = el_q;
  assign col_addr_o = col_q;
  assign w_row_o    = w_row_q;
  assign el_wrap_o  = el_wrap;  // Qualified with shift in the cache

endmodule

//--- wbuf_gidx_cache.sv
`timescale 1ns/1ps

module wbuf_gidx_cache #(
  parameter  int unsigned DW     = wbuf_pkg::DEF_DW,
  parameter  int unsigned Height = wbuf_pkg::DEF_HEIGHT,
  parameter  int unsigned NRegs  = wbuf_pkg::DEF_NREGS,
  parameter  int unsigned GidxW  = wbuf_pkg::DEF_GIDX_W,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          load_i,
  input  logic                          shift_i,
  input  logic                          dequant_i,
  input  logic                          el_wrap_i,    // Last element of a pass
  input  logic              [RowW-1:0]  w_row_i,      // PE row being loaded
  input  logic              [GidxW-1:0] gidx_i,
  output logic                          gidx_present_o,
  output logic              [RowW-1:0]  evict_ptr_o,
  output logic [Height-1:0] [RowW-1:0]  row_addr_o
);

  import wbuf_pkg::*;

  localparam int unsigned D    = DW / ELEM_W;
  localparam int unsigned E    = NRegs + 1;
  localparam int unsigned C    = D / E;
  localparam int unsigned CntW = (C > 1) ? $clog2(C) : 1;

  // Read tags per PE row, write tags per storage row
  logic [Height-1:0][GidxW-1:0] r_tag_q, w_tag_q;
  logic [Height-1:0]            r_vld_q, w_vld_q;
  logic [Height-1:0][CntW-1:0]  usage_q;

  logic dq_load;
  logic dq_alloc;
  logic [Height-1:0] tag_hit;

  assign dq_load  = load_i && dequant_i;
  assign dq_alloc = dq_load && !gidx_present_o;  // New group takes a storage row

  // Group lookup against stored rows
  for (genvar h = 0; h < Height; h++) begin : gen_hit
    assign tag_hit[h] = w_vld_q[h] && (w_tag_q[h] == gidx_i);
  end
  assign gidx_present_o = |tag_hit;

  for (genvar h = 0; h < Height; h++) begin : gen_tags
    // Tag of the group each PE row consumes
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        r_tag_q[h] <= '0;
        r_vld_q[h] <= 1'b0;
      end else if (clear_i) begin
        r_tag_q[h] <= '0;
        r_vld_q[h] <= 1'b0;
      end else if (dq_load && w_row_i == RowW'(h)) begin
        r_tag_q[h] <= gidx_i;
        r_vld_q[h] <= 1'b1;
      end
    end

    // Tag of the group held in each storage row
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        w_tag_q[h] <= '0;
        w_vld_q[h] <= 1'b0;
      end else if (clear_i) begin
        w_tag_q[h] <= '0;
        w_vld_q[h] <= 1'b0;
      end else if (dq_alloc && evict_ptr_o == RowW'(h)) begin
        w_tag_q[h] <= gidx_i;
        w_vld_q[h] <= 1'b1;
      end
    end

    // Remaining passes before the row may be replaced
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        usage_q[h] <= '0;
      end else if (clear_i) begin
        usage_q[h] <= '0;
      end else if (dq_alloc && evict_ptr_o == RowW'(h)) begin
        usage_q[h] <= CntW'(C - 1);
      end else if (shift_i && el_wrap_i && usage_q[h] != '0) begin
        usage_q[h] <= usage_q[h] - 1'b1;
      end
    end
  end

  // Lowest exhausted row, scanned from the top so the lowest wins
  always_comb begin
    evict_ptr_o = '0;
    for (int h = Height - 1; h >= 0; h--) begin
      if (usage_q[h] == '0) begin
        evict_ptr_o = RowW'(h);
      end
    end
  end

  // Lane to storage row mapping
  always_comb begin
    for (int h = 0; h < Height; h++) begin
      row_addr_o[h] = RowW'(h);  // Identity in plain mode or on a miss
      if (dequant_i) begin
        for (int hh = Height - 1; hh >= 0; hh--) begin
          if (r_vld_q[h] && w_vld_q[hh] && r_tag_q[h] == w_tag_q[hh]) begin
            row_addr_o[h] = RowW'(hh);
          end
        end
      end
    end
  end

endmodule

//--- wbuf_pkg.sv
package wbuf_pkg;

  // Element format is fixed
  localparam int unsigned ELEM_W = 16;

  // Defaults for the top level parameters
  localparam int unsigned DEF_DW     = 64;  // Four elements per input word
  localparam int unsigned DEF_HEIGHT = 4;   // PE rows
  localparam int unsigned DEF_NREGS  = 1;   // Pipeline registers per PE
  localparam int unsigned DEF_GIDX_W = 3;   // Group index bits

  // One weight or scale element
  typedef logic [ELEM_W-1:0] elem_t;

  // Programmed row width and row count
  typedef logic [7:0] dim_t;

  // Control from the engine sequencer
  typedef struct packed {
    logic load;     // Row present on w_buffer_i
    logic shift;    // Advance read position
    logic dequant;  // Scale vectors tagged by group
    dim_t width;    // Valid elements per row
    dim_t height;   // Valid rows
  } wbuf_ctrl_t;

  // Status back to the sequencer
  typedef struct packed {
    logic w_ready;  // Offered row is written this cycle
  } wbuf_flags_t;

endpackage

//--- wbuf_scm.sv
`timescale 1ns/1ps

module wbuf_scm #(
  parameter  int unsigned DW     = wbuf_pkg::DEF_DW,
  parameter  int unsigned Height = wbuf_pkg::DEF_HEIGHT,
  parameter  int unsigned NRegs  = wbuf_pkg::DEF_NREGS,
  localparam int unsigned D      = DW / wbuf_pkg::ELEM_W,
  localparam int unsigned E      = NRegs + 1,
  localparam int unsigned C      = D / E,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1,
  localparam int unsigned ElW    = (E > 1) ? $clog2(E) : 1,
  localparam int unsigned ColW   = (C > 1) ? $clog2(C) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  // Write port, one full row at a time
  input  logic                              write_en_i,
  input  logic               [RowW-1:0]     write_addr_i,
  input  wbuf_pkg::elem_t    [D-1:0]        wdata_i,
  // Read position shared by all lanes
  input  logic               [ElW-1:0]      el_addr_i,
  input  logic               [ColW-1:0]     col_addr_i,
  // Each lane picks its own storage row
  input  logic [Height-1:0]  [RowW-1:0]     row_addr_i,
  output wbuf_pkg::elem_t    [Height-1:0]   rdata_o
);

  import wbuf_pkg::*;

  elem_t [Height-1:0][D-1:0] mem_q;
  logic  [Height-1:0]        row_we;

  // Row select decode
  always_comb begin
    row_we = '0;
    if (write_en_i) begin
      row_we[write_addr_i] = 1'b1;
    end
  end

  for (genvar r = 0; r < Height; r++) begin : gen_row
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mem_q[r] <= '0;
      end else if (clear_i) begin
        mem_q[r] <= '0;
      end else if (row_we[r]) begin
        mem_q[r] <= wdata_i;  // Whole padded row at once
      end
    end
  end

  // Element col*E+el of the row this lane is mapped to
  for (genvar h = 0; h < Height; h++) begin : gen_read_lane
    always_comb begin
      int unsigned idx;
      idx = int'(col_addr_i) * E + int'(el_addr_i);
      rdata_o[h] = mem_q[row_addr_i[h]][idx];
    end
  end

endmodule

//--- wbuf_top.sv
`timescale 1ns/1ps

module wbuf_top #(
  parameter  int unsigned DW     = wbuf_pkg::DEF_DW,
  parameter  int unsigned Height = wbuf_pkg::DEF_HEIGHT,
  parameter  int unsigned NRegs  = wbuf_pkg::DEF_NREGS,
  parameter  int unsigned GidxW  = wbuf_pkg::DEF_GIDX_W,
  localparam int unsigned D      = DW / wbuf_pkg::ELEM_W,
  localparam int unsigned E      = NRegs + 1,
  localparam int unsigned C      = D / E,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1,
  localparam int unsigned ElW    = (E > 1) ? $clog2(E) : 1,
  localparam int unsigned ColW   = (C > 1) ? $clog2(C) : 1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  wbuf_pkg::wbuf_ctrl_t             ctrl_i,
  input  logic            [DW-1:0]         w_buffer_i,  // Weight row or scale vector
  input  logic            [GidxW-1:0]      gidx_i,
  output wbuf_pkg::wbuf_flags_t            flags_o,
  output wbuf_pkg::elem_t [Height-1:0]     w_buffer_o
);

  import wbuf_pkg::*;

  logic                         write_en;
  logic [RowW-1:0]              write_addr;
  elem_t [D-1:0]                wdata;
  logic [ElW-1:0]               el_addr;
  logic [ColW-1:0]              col_addr;
  logic [RowW-1:0]              w_row;
  logic                         el_wrap;
  logic                         gidx_present;
  logic [RowW-1:0]              evict_ptr;
  logic [Height-1:0][RowW-1:0]  row_addr;

  wbuf_ctrl #(
    .DW     (DW),
    .Height (Height),
    .NRegs  (NRegs)
  ) i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .ctrl_i         (ctrl_i),
    .w_buffer_i     (w_buffer_i),
    .gidx_present_i (gidx_present),
    .evict_ptr_i    (evict_ptr),
    .flags_o        (flags_o),
    .write_en_o     (write_en),
    .write_addr_o   (write_addr),
    .wdata_o        (wdata),
    .el_addr_o      (el_addr),
    .col_addr_o     (col_addr),
    .w_row_o        (w_row),
    .el_wrap_o      (el_wrap)
  );

  wbuf_gidx_cache #(
    .DW     (DW),
    .Height (Height),
    .NRegs  (NRegs),
    .GidxW  (GidxW)
  ) i_gidx_cache (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .load_i         (ctrl_i.load),
    .shift_i        (ctrl_i.shift),
    .dequant_i      (ctrl_i.dequant),
    .el_wrap_i      (el_wrap),
    .w_row_i        (w_row),
    .gidx_i         (gidx_i),
    .gidx_present_o (gidx_present),
    .evict_ptr_o    (evict_ptr),
    .row_addr_o     (row_addr)
  );

  wbuf_scm #(
    .DW     (DW),
    .Height (Height),
    .NRegs  (NRegs)
  ) i_scm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .write_en_i   (write_en),
    .write_addr_i (write_addr),
    .wdata_i      (wdata),
    .el_addr_i    (el_addr),
    .col_addr_i   (col_addr),
    .row_addr_i   (row_addr),
    .rdata_o      (w_buffer_o)
  );

endmodule
